//--- logic/cc_params_pkg.sv
package cc_params_pkg;

    // Gap registers, all in clock cycles
    localparam int GAP_W        = 16;
    localparam int GAP_INIT     = 16;     // Current and target after reset
    localparam int GAP_MIN      = 4;
    localparam int GAP_MAX      = 1024;
    localparam int GAP_AI       = 2;      // Target shrink per increase step

    // Alpha is an 8-bit fraction, ALPHA_ONE is 1.0
    localparam int ALPHA_ONE    = 256;
    localparam int ALPHA_G      = 16;     // Gain g = 1/16

    // Spacing between two decreases, also the alpha decay window
    localparam int MARK_HOLDOFF = 50;

    // Additive increase fires after PERIOD_F time periods or PERIOD_F releases
    localparam int PERIOD_F     = 5;
    localparam int TIME_PERIOD  = 100;    // Cycles per time period

endpackage

//--- logic/req_pkg.sv
package req_pkg;

    localparam int QP_W    = 4;     // Queue-pair number
    localparam int VADDR_W = 48;    // Virtual address
    localparam int LEN_W   = 28;    // Transfer length

    // Read and write carry the same fields
    typedef enum logic {
        OP_RD = 1'b0,
        OP_WR = 1'b1
    } op_t;

endpackage

//--- logic/req_dispatch.sv
`timescale 1ns/1ps

module req_dispatch
    import req_pkg::*;
#(
    parameter int N_QP = 4
) (
    input  logic                aclk,
    input  logic                aresetn,

    input  logic                s_req_valid,
    output logic                s_req_ready,
    input  logic [QP_W-1:0]     s_req_qp,
    input  op_t                 s_req_op,
    input  logic [VADDR_W-1:0]  s_req_vaddr,
    input  logic [LEN_W-1:0]    s_req_len,

    input  logic                ecn_valid,
    input  logic [QP_W-1:0]     ecn_qp,
    input  logic                ecn_mark,

    output logic [N_QP-1:0]     enq_valid,
    input  logic [N_QP-1:0]     enq_ready,
    output op_t                 enq_op,
    output logic [VADDR_W-1:0]  enq_vaddr,
    output logic [LEN_W-1:0]    enq_len,

    output logic [N_QP-1:0]     lane_ecn_valid,
    output logic                lane_ecn_mark
);

    logic [N_QP-1:0] req_sel;
    logic [N_QP-1:0] ecn_sel;

    always_comb begin
        for (int i = 0; i < N_QP; i++) begin
            req_sel[i] = (s_req_qp == QP_W'(i));
            ecn_sel[i] = (ecn_qp == QP_W'(i));
        end
    end

    assign enq_valid   = s_req_valid ? req_sel : '0;
    assign s_req_ready = |(req_sel & enq_ready);   // QP with no lane is never taken
    assign enq_op      = s_req_op;
    assign enq_vaddr   = s_req_vaddr;
    assign enq_len     = s_req_len;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            lane_ecn_valid <= '0;
        end else begin
            lane_ecn_valid <= ecn_valid ? ecn_sel : '0;
        end
    end

    always_ff @(posedge aclk) begin
        lane_ecn_mark <= ecn_mark;
    end

endmodule

//--- logic/cc_rate_ctrl.sv
`timescale 1ns/1ps

module cc_rate_ctrl
    import cc_params_pkg::*;
(
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             ecn_valid,
    input  logic             ecn_mark,
    input  logic             sent,
    output logic [GAP_W-1:0] gap
);

    localparam int FRAC_W  = $clog2(ALPHA_ONE);
    localparam int ALPHA_W = FRAC_W + 1;
    localparam int TP_W    = $clog2(TIME_PERIOD);
    localparam int PF_W    = $clog2(PERIOD_F + 1);

    logic [GAP_W-1:0]   target;
    logic [ALPHA_W-1:0] alpha;
    logic [31:0]        timer;
    logic [31:0]        last_dec;
    logic [31:0]        last_mark;
    logic [TP_W-1:0]    tp_cnt;
    logic               tp_tick;
    logic [PF_W-1:0]    period_cnt;
    logic [PF_W-1:0]    rel_cnt;

    logic               marked;
    logic               dec_now;
    logic               decay;
    logic               ai_time;
    logic               ai_byte;
    logic [31:0]        grow_num;
    logic [31:0]        grow_den;
    logic [31:0]        grow_q;
    logic [GAP_W-1:0]   gap_grown;
    logic [GAP_W:0]     gap_sum;
    logic [GAP_W-1:0]   target_ai;
    logic [31:0]        alpha_keep;

    assign marked  = ecn_valid && ecn_mark;
    assign dec_now = marked && ((timer - last_dec) > MARK_HOLDOFF);
    assign decay   = (timer - last_mark) >= MARK_HOLDOFF;
    assign tp_tick = (tp_cnt == TP_W'(TIME_PERIOD - 1));
    assign ai_time = period_cnt >= PERIOD_F;
    assign ai_byte = rel_cnt >= PERIOD_F;

    // gap / (1 - alpha/2), a longer gap is a lower rate
    assign grow_num  = 32'(gap) << FRAC_W;
    assign grow_den  = 32'(ALPHA_ONE) - 32'(alpha >> 1);
    assign grow_q    = grow_num / grow_den;
    assign gap_grown = (grow_q > GAP_MAX) ? GAP_W'(GAP_MAX) : grow_q[GAP_W-1:0];

    assign gap_sum    = gap + target;
    assign target_ai  = (target >= GAP_MIN + GAP_AI) ? target - GAP_W'(GAP_AI)
                                                     : GAP_W'(GAP_MIN);
    assign alpha_keep = (32'(ALPHA_ONE - ALPHA_G) * 32'(alpha)) >> FRAC_W;   // (1-g)*alpha

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            gap        <= GAP_W'(GAP_INIT);
            target     <= GAP_W'(GAP_INIT);
            alpha      <= ALPHA_W'(ALPHA_ONE);
            timer      <= '0;
            last_dec   <= '0;
            last_mark  <= '0;
            tp_cnt     <= '0;
            period_cnt <= '0;
            rel_cnt    <= '0;
        end else begin
            timer      <= timer + 1;
            tp_cnt     <= tp_tick ? '0 : tp_cnt + 1'b1;
            period_cnt <= ai_time ? PF_W'(tp_tick) : period_cnt + PF_W'(tp_tick);
            rel_cnt    <= ai_byte ? PF_W'(sent) : rel_cnt + PF_W'(sent);

            if (dec_now) begin
                target   <= gap;
                gap      <= gap_grown;
                alpha    <= ALPHA_W'(alpha_keep + ALPHA_G);
                last_dec <= timer;
            end else begin
                if (ai_time || ai_byte) begin
                    target <= target_ai;
                end
                if (!marked) begin
                    gap <= gap_sum[GAP_W:1];   // Fast recovery
                end
                if (decay) begin
                    alpha <= ALPHA_W'(alpha_keep);
                end
            end

            // Quiet window restarts on every mark and on every decay step
            if (marked || decay) begin
                last_mark <= timer;
            end
        end
    end

endmodule

//--- logic/cc_lane.sv
`timescale 1ns/1ps

module cc_lane
    import req_pkg::*;
    import cc_params_pkg::*;
#(
    parameter int QDEPTH = 8
) (
    input  logic                aclk,
    input  logic                aresetn,

    input  logic                enq_valid,
    output logic                enq_ready,
    input  op_t                 enq_op,
    input  logic [VADDR_W-1:0]  enq_vaddr,
    input  logic [LEN_W-1:0]    enq_len,

    input  logic                ecn_valid,
    input  logic                ecn_mark,

    output logic                deq_valid,
    input  logic                deq_ready,
    output op_t                 deq_op,
    output logic [VADDR_W-1:0]  deq_vaddr,
    output logic [LEN_W-1:0]    deq_len
);

    localparam int PTR_W = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;

    op_t                mem_op    [QDEPTH];
    logic [VADDR_W-1:0] mem_vaddr [QDEPTH];
    logic [LEN_W-1:0]   mem_len   [QDEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic [GAP_W-1:0]   pace_cnt;
    logic [GAP_W-1:0]   gap;
    logic               held;
    logic               do_enq;
    logic               do_deq;

    assign enq_ready = (count < QDEPTH);
    assign do_enq    = enq_valid && enq_ready;
    assign do_deq    = deq_valid && deq_ready;

    // Once offered the head stays offered, even if the gap grows
    assign deq_valid = (count != '0) && (held || (pace_cnt >= gap));
    assign deq_op    = mem_op[rd_ptr];
    assign deq_vaddr = mem_vaddr[rd_ptr];
    assign deq_len   = mem_len[rd_ptr];

    always_ff @(posedge aclk) begin
        if (do_enq) begin
            mem_op[wr_ptr]    <= enq_op;
            mem_vaddr[wr_ptr] <= enq_vaddr;
            mem_len[wr_ptr]   <= enq_len;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            pace_cnt <= '0;
            held     <= 1'b0;
        end else begin
            if (do_enq) begin
                wr_ptr <= (wr_ptr == PTR_W'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= (rd_ptr == PTR_W'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(do_enq) - (PTR_W + 1)'(do_deq);

            if (do_deq) begin
                pace_cnt <= '0;
            end else if (pace_cnt < GAP_MAX) begin
                pace_cnt <= pace_cnt + 1'b1;   // Saturates at GAP_MAX
            end

            if (do_deq) begin
                held <= 1'b0;
            end else if (deq_valid) begin
                held <= 1'b1;
            end
        end
    end

    cc_rate_ctrl u_rate (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .ecn_valid (ecn_valid),
        .ecn_mark  (ecn_mark),
        .sent      (do_deq),
        .gap       (gap)
    );

endmodule

//--- logic/req_merge.sv
`timescale 1ns/1ps

module req_merge
    import req_pkg::*;
#(
    parameter int N_QP = 4
) (
    input  logic                           aclk,
    input  logic                           aresetn,

    input  logic [N_QP-1:0]                deq_valid,
    output logic [N_QP-1:0]                deq_ready,
    input  op_t  [N_QP-1:0]                deq_op,
    input  logic [N_QP-1:0][VADDR_W-1:0]   deq_vaddr,
    input  logic [N_QP-1:0][LEN_W-1:0]     deq_len,

    output logic                           m_req_valid,
    input  logic                           m_req_ready,
    output logic [QP_W-1:0]                m_req_qp,
    output op_t                            m_req_op,
    output logic [VADDR_W-1:0]             m_req_vaddr,
    output logic [LEN_W-1:0]               m_req_len
);

    localparam int IDX_W = (N_QP > 1) ? $clog2(N_QP) : 1;

    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] lock_idx;
    logic             locked;
    logic [IDX_W-1:0] grant;
    logic [IDX_W-1:0] next_ptr;

    always_comb begin
        int idx;
        grant       = rr_ptr;
        m_req_valid = 1'b0;
        for (int k = 0; k < N_QP; k++) begin
            idx = int'(rr_ptr) + k;
            if (idx >= N_QP) begin
                idx = idx - N_QP;
            end
            if (!m_req_valid && deq_valid[idx]) begin
                grant       = IDX_W'(idx);
                m_req_valid = 1'b1;
            end
        end
        if (locked) begin
            grant       = lock_idx;   // Keep a stalled grant in place
            m_req_valid = deq_valid[lock_idx];
        end
        deq_ready        = '0;
        deq_ready[grant] = m_req_valid && m_req_ready;
    end

    assign m_req_qp    = QP_W'(grant);
    assign m_req_op    = deq_op[grant];
    assign m_req_vaddr = deq_vaddr[grant];
    assign m_req_len   = deq_len[grant];
    assign next_ptr    = (grant == IDX_W'(N_QP - 1)) ? '0 : grant + 1'b1;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rr_ptr   <= '0;
            locked   <= 1'b0;
            lock_idx <= '0;
        end else begin
            if (m_req_valid && m_req_ready) begin
                rr_ptr <= next_ptr;
            end
            locked   <= m_req_valid && !m_req_ready;
            lock_idx <= grant;
        end
    end

endmodule

//--- logic/cc_top.sv
`timescale 1ns/1ps

module cc_top
    import req_pkg::*;
#(
    parameter int N_QP   = 4,
    parameter int QDEPTH = 8
) (
    input  logic                aclk,
    input  logic                aresetn,

    input  logic                s_req_valid,
    output logic                s_req_ready,
    input  logic [QP_W-1:0]     s_req_qp,
    input  op_t                 s_req_op,
    input  logic [VADDR_W-1:0]  s_req_vaddr,
    input  logic [LEN_W-1:0]    s_req_len,

    input  logic                ecn_valid,
    input  logic [QP_W-1:0]     ecn_qp,
    input  logic                ecn_mark,

    output logic                m_req_valid,
    input  logic                m_req_ready,
    output logic [QP_W-1:0]     m_req_qp,
    output op_t                 m_req_op,
    output logic [VADDR_W-1:0]  m_req_vaddr,
    output logic [LEN_W-1:0]    m_req_len
);

    logic [N_QP-1:0]              enq_valid;
    logic [N_QP-1:0]              enq_ready;
    op_t                          enq_op;
    logic [VADDR_W-1:0]           enq_vaddr;
    logic [LEN_W-1:0]             enq_len;
    logic [N_QP-1:0]              lane_ecn_valid;
    logic                         lane_ecn_mark;
    logic [N_QP-1:0]              deq_valid;
    logic [N_QP-1:0]              deq_ready;
    op_t  [N_QP-1:0]              deq_op;
    logic [N_QP-1:0][VADDR_W-1:0] deq_vaddr;
    logic [N_QP-1:0][LEN_W-1:0]   deq_len;

    req_dispatch #(
        .N_QP (N_QP)
    ) u_dispatch (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .s_req_valid    (s_req_valid),
        .s_req_ready    (s_req_ready),
        .s_req_qp       (s_req_qp),
        .s_req_op       (s_req_op),
        .s_req_vaddr    (s_req_vaddr),
        .s_req_len      (s_req_len),
        .ecn_valid      (ecn_valid),
        .ecn_qp         (ecn_qp),
        .ecn_mark       (ecn_mark),
        .enq_valid      (enq_valid),
        .enq_ready      (enq_ready),
        .enq_op         (enq_op),
        .enq_vaddr      (enq_vaddr),
        .enq_len        (enq_len),
        .lane_ecn_valid (lane_ecn_valid),
        .lane_ecn_mark  (lane_ecn_mark)
    );

    for (genvar i = 0; i < N_QP; i++) begin : lane_gen
        cc_lane #(
            .QDEPTH (QDEPTH)
        ) u_lane (
            .aclk      (aclk),
            .aresetn   (aresetn),
            .enq_valid (enq_valid[i]),
            .enq_ready (enq_ready[i]),
            .enq_op    (enq_op),
            .enq_vaddr (enq_vaddr),
            .enq_len   (enq_len),
            .ecn_valid (lane_ecn_valid[i]),
            .ecn_mark  (lane_ecn_mark),
            .deq_valid (deq_valid[i]),
            .deq_ready (deq_ready[i]),
            .deq_op    (deq_op[i]),
            .deq_vaddr (deq_vaddr[i]),
            .deq_len   (deq_len[i])
        );
    end

    req_merge #(
        .N_QP (N_QP)
    ) u_merge (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .deq_valid   (deq_valid),
        .deq_ready   (deq_ready),
        .deq_op      (deq_op),
        .deq_vaddr   (deq_vaddr),
        .deq_len     (deq_len),
        .m_req_valid (m_req_valid),
        .m_req_ready (m_req_ready),
        .m_req_qp    (m_req_qp),
        .m_req_op    (m_req_op),
        .m_req_vaddr (m_req_vaddr),
        .m_req_len   (m_req_len)
    );

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk    = 1'b0;
        aresetn = 1'b0;
        repeat (10) @(posedge aclk);
        aresetn <= 1'b1;   // Released on a rising edge
    end

    always #2 aclk = ~aclk;   // 4 ns period

endmodule

//--- bench/tb_cc_top.sv
`timescale 1ns/1ps

module tb_cc_top
    import req_pkg::*;
    import cc_params_pkg::*;
;

    localparam int N_QP   = 4;
    localparam int QDEPTH = 8;

    typedef struct packed {
        op_t                op;
        logic [VADDR_W-1:0] vaddr;
        logic [LEN_W-1:0]   len;
    } req_t;

    logic aclk, aresetn;
    logic s_req_valid, s_req_ready, ecn_valid, ecn_mark, m_req_valid, m_req_ready;
    logic [QP_W-1:0] s_req_qp, ecn_qp, m_req_qp;
    op_t s_req_op, m_req_op;
    logic [VADDR_W-1:0] s_req_vaddr, m_req_vaddr;
    logic [LEN_W-1:0] s_req_len, m_req_len;

    req_t exp_q [N_QP][$];   // Model queue per lane
    int   last_rel [N_QP];
    int   last_iv [N_QP];
    int   iv_sum [N_QP];
    int   iv_cnt [N_QP];
    int   iv_min [N_QP];
    int   iv_max [N_QP];
    bit   marked_any [N_QP];
    int   cyc, err_cnt, pace_err, n_issue, issue_limit, feed_mode, stall_seen;
    int   n_pass, n_fail;
    bit   flood, rand_ready, hold_prev;
    req_t prev_req;
    logic [QP_W-1:0] prev_qp;

    tb_clk_gen u_clk_gen (.aclk(aclk), .aresetn(aresetn));

    cc_top #(.N_QP(N_QP), .QDEPTH(QDEPTH)) u_cc_top (
        .aclk(aclk), .aresetn(aresetn),
        .s_req_valid(s_req_valid), .s_req_ready(s_req_ready), .s_req_qp(s_req_qp),
        .s_req_op(s_req_op), .s_req_vaddr(s_req_vaddr), .s_req_len(s_req_len),
        .ecn_valid(ecn_valid), .ecn_qp(ecn_qp), .ecn_mark(ecn_mark),
        .m_req_valid(m_req_valid), .m_req_ready(m_req_ready), .m_req_qp(m_req_qp),
        .m_req_op(m_req_op), .m_req_vaddr(m_req_vaddr), .m_req_len(m_req_len)
    );

    task automatic check_value(input string sig, input longint expv, input longint actv);
        if (expv != actv) begin
            $display("ERROR t=%0t %s expected %0h got %0h", $time, sig, expv, actv);
            err_cnt++;
        end
    endtask

    task automatic clear_stats();
        for (int i = 0; i < N_QP; i++) begin
            iv_sum[i] = 0;
            iv_cnt[i] = 0;
            iv_min[i] = 32'h7fff_ffff;
            iv_max[i] = 0;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        if (ok) n_pass++;
        else n_fail++;
        $display("%s: %s", name, ok ? "PASS" : "FAIL");
    endtask

    task automatic drain_lanes(input int max_cycles, output bit ok);
        bit busy;
        ok = 1'b0;
        for (int t = 0; t < max_cycles && !ok; t++) begin
            @(negedge aclk);
            busy = s_req_valid || (feed_mode == 1 && n_issue < issue_limit);
            for (int i = 0; i < N_QP; i++) busy |= (exp_q[i].size() != 0);
            ok = !busy;
        end
        if (!ok) $display("Timeout: requests still queued after %0d cycles", max_cycles);
    endtask

    // Monitor first, then drive the next cycle's inputs
    always @(posedge aclk) begin : mon_drive
        int   q, iv, pick, start;
        req_t r;
        if (aresetn) begin
            if (hold_prev) begin
                if (!m_req_valid) begin
                    $display("t=%0t m_req_valid dropped while stalled", $time);
                    err_cnt++;
                end
                check_value("m_req_qp (stalled)", prev_qp, m_req_qp);
                check_value("m_req_op (stalled)", prev_req.op, m_req_op);
                check_value("m_req_vaddr (stalled)", prev_req.vaddr, m_req_vaddr);
                check_value("m_req_len (stalled)", prev_req.len, m_req_len);
            end
            hold_prev = m_req_valid && !m_req_ready;
            prev_qp   = m_req_qp;
            prev_req  = '{m_req_op, m_req_vaddr, m_req_len};
            if (s_req_valid && s_req_qp < N_QP) begin
                check_value("s_req_ready", exp_q[s_req_qp].size() < QDEPTH, s_req_ready);
                if (!s_req_ready) stall_seen++;
                if (s_req_ready) exp_q[s_req_qp].push_back(req_t'{s_req_op, s_req_vaddr, s_req_len});
            end
            if (m_req_valid && m_req_ready) begin
                q = m_req_qp;
                if (q >= N_QP || exp_q[q].size() == 0) begin
                    $display("t=%0t output from lane %0d with nothing queued", $time, q);
                    err_cnt++;
                end else begin
                    r = exp_q[q].pop_front();
                    check_value("m_req_op", r.op, m_req_op);
                    check_value("m_req_vaddr", r.vaddr, m_req_vaddr);
                    check_value("m_req_len", r.len, m_req_len);
                    if (last_rel[q] < 0 && cyc < GAP_INIT) begin
                        $display("ERROR t=%0t lane %0d first release expected >= %0d got %0d",
                                 $time, q, GAP_INIT, cyc);
                        pace_err++;
                    end else if (last_rel[q] >= 0) begin
                        iv = cyc - last_rel[q];
                        if (!marked_any[q] && iv < GAP_MIN) begin
                            $display("ERROR t=%0t lane %0d interval expected >= %0d got %0d",
                                     $time, q, GAP_MIN, iv);
                            pace_err++;
                        end
                        last_iv[q] = iv;
                        iv_sum[q] += iv;
                        iv_cnt[q]++;
                        if (iv < iv_min[q]) iv_min[q] = iv;
                        if (iv > iv_max[q]) iv_max[q] = iv;
                    end
                    last_rel[q] = cyc;
                end
            end
            cyc++;

            ecn_valid   <= flood;
            ecn_qp      <= '0;
            ecn_mark    <= 1'b1;
            if (flood) marked_any[0] = 1'b1;
            m_req_ready <= rand_ready ? 1'($urandom) : 1'b1;
            if (!(s_req_valid && !s_req_ready)) begin   // Hold a stalled request
                pick = -1;
                if (feed_mode == 1 && n_issue < issue_limit) begin
                    pick = $urandom % N_QP;
                end else if (feed_mode == 2) begin
                    start = $urandom % N_QP;
                    for (int k = 0; k < N_QP; k++) begin
                        if (pick < 0 && exp_q[(start + k) % N_QP].size() < QDEPTH)
                            pick = (start + k) % N_QP;
                    end
                end
                s_req_valid <= (pick >= 0);
                if (pick >= 0) begin
                    s_req_qp    <= QP_W'(pick);
                    s_req_op    <= op_t'($urandom % 2);
                    s_req_vaddr <= VADDR_W'({$urandom, $urandom});
                    s_req_len   <= LEN_W'($urandom);
                    n_issue++;
                end
            end
        end
    end

    initial begin
        bit ok, ok4, drained;
        int e0;
        s_req_valid = 1'b0;
        s_req_qp    = '0;
        s_req_op    = OP_RD;
        s_req_vaddr = '0;
        s_req_len   = '0;
        ecn_valid   = 1'b0;
        ecn_qp      = '0;
        ecn_mark    = 1'b0;
        m_req_ready = 1'b1;
        {cyc, err_cnt, pace_err, n_issue, issue_limit, feed_mode, stall_seen} = '0;
        {n_pass, n_fail, flood, rand_ready, hold_prev} = '0;
        for (int i = 0; i < N_QP; i++) begin
            last_rel[i]   = -1;
            last_iv[i]    = 0;
            marked_any[i] = 1'b0;
        end
        clear_stats();
        void'($urandom(32'h39e1_ce53));

        ok = 1'b0;
        for (int t = 0; t < 100 && !ok; t++) begin
            @(negedge aclk);
            ok = aresetn;
        end
        if (!ok) $display("Timeout: reset was never released");

        e0 = err_cnt;
        issue_limit = 200;
        feed_mode = 1;
        drain_lanes(20000, ok);
        feed_mode = 0;
        report_test("Test 1 integrity and order", ok && err_cnt == e0);

        ok = (pace_err == 0);
        for (int i = 0; i < N_QP; i++) begin
            if (last_rel[i] < 0) begin
                $display("Lane %0d never released a request", i);
                ok = 1'b0;
            end
        end
        report_test("Test 2 initial pacing", ok);

        e0 = err_cnt;
        stall_seen = 0;
        n_issue = 0;
        issue_limit = 150;
        rand_ready = 1'b1;
        feed_mode = 1;
        drain_lanes(40000, ok);
        feed_mode = 0;
        rand_ready = 1'b0;
        if (stall_seen == 0) $display("s_req_ready never dropped under back-pressure");
        report_test("Test 5 back-pressure", ok && err_cnt == e0 && stall_seen > 0);

        clear_stats();
        for (int i = 0; i < N_QP; i++) begin
            last_rel[i] = -1;   // Idle time before the refill is not an interval
        end
        last_iv[0] = 0;
        feed_mode = 2;
        flood = 1'b1;
        ok = 1'b0;
        for (int t = 0; t < 20000 && !ok; t++) begin
            @(negedge aclk);
            ok = (last_iv[0] > 4 * GAP_INIT);
        end
        flood = 1'b0;
        if (!ok) $display("Timeout: lane 0 interval never grew under marks");
        ok4 = ok;
        for (int i = 1; i < N_QP; i++) begin
            if (iv_cnt[i] == 0 || iv_min[i] < GAP_MIN || iv_max[i] >= GAP_INIT) begin
                $display("Lane %0d intervals %0d..%0d over %0d releases out of range",
                         i, iv_min[i], iv_max[i], iv_cnt[i]);
                ok4 = 1'b0;
            end
        end
        clear_stats();
        for (int t = 0; t < 10000 && iv_cnt[0] < 3; t++) @(negedge aclk);
        if (iv_cnt[0] < 3) $display("Timeout: lane 0 released too few requests after marks");
        if (iv_cnt[0] >= 3 && iv_sum[0] <= GAP_INIT * iv_cnt[0]) begin
            $display("ERROR t=%0t lane 0 mean interval expected > %0d got %0d",
                     $time, GAP_INIT, iv_sum[0] / iv_cnt[0]);
            ok = 1'b0;
        end
        report_test("Test 3 decrease on marks", ok && iv_cnt[0] >= 3);
        report_test("Test 4 lane isolation", ok4);

        ok = 1'b0;
        for (int t = 0; t < 60000 && !ok; t++) begin
            @(negedge aclk);
            ok = (last_iv[0] < GAP_INIT);
        end
        if (!ok) $display("Timeout: lane 0 interval never recovered below %0d", GAP_INIT);
        feed_mode = 0;
        drain_lanes(40000, drained);
        report_test("Test 6 recovery", ok && drained);

        $display("Tests passed %0d failed %0d, value errors %0d, pacing errors %0d",
                 n_pass, n_fail, err_cnt, pace_err);
        if (n_fail == 0 && err_cnt == 0 && pace_err == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
logic/cc_params_pkg.sv
logic/req_pkg.sv
logic/req_dispatch.sv
logic/cc_rate_ctrl.sv
logic/cc_lane.sv
logic/req_merge.sv
logic/cc_top.sv
bench/tb_clk_gen.sv
bench/tb_cc_top.sv
